// File: logic/rt_dispatch_pkg.sv
`default_nettype none

package rt_dispatch_pkg;

    // default sizes, taken by the top level parameters
    localparam int NUM_RT      = 4;
    localparam int NUM_THREAD  = 32;
    localparam int QUEUE_DEPTH = 8;
    localparam int THREAD_W    = $clog2(NUM_THREAD);

    // stack bytes per thread
    localparam logic [31:0] STACK_STRIDE = 32'h400;

    typedef logic [THREAD_W-1:0] thread_id_t;

    // thread context, moves generator -> queue -> dispatcher -> core
    typedef struct packed {
        logic [31:0] pixel_id;
        thread_id_t  thread_id;
        logic [31:0] pc;
        logic [31:0] sp;
    } job_ctx_t;

    typedef struct packed {
        logic [31:0] base_pixel;
        logic [15:0] pixel_count;
        logic [31:0] entry_pc;
    } patch_cfg_t;

    // one per core, at most one flag set
    typedef struct packed {
        logic     task_done;
        logic     context_switch;
        job_ctx_t saved;
    } core_report_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // register byte offsets
    typedef enum logic [7:0] {
        REG_CTRL   = 8'h00,
        REG_BASE   = 8'h04,
        REG_COUNT  = 8'h08,
        REG_PC     = 8'h0C,
        REG_STATUS = 8'h10
    } reg_addr_e;

endpackage

`default_nettype wire

// File: logic/patch_regs.sv
`default_nettype none

module patch_regs (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire rt_dispatch_pkg::apb_req_t   apb_req,
    output rt_dispatch_pkg::apb_rsp_t        apb_rsp,
    input  wire logic                        patch_done,
    input  wire logic                        busy,
    output logic                             start,
    output rt_dispatch_pkg::patch_cfg_t      cfg
);
    import rt_dispatch_pkg::*;

    reg_addr_e   addr;
    logic        access;
    logic        addr_hit;
    logic        cfg_addr;
    logic        cfg_locked;
    logic        wr_ok;
    logic        done_flag;
    logic [31:0] rd_data;

    // access phase of the transfer, no wait states
    assign access = apb_req.psel && apb_req.penable;
    assign addr   = reg_addr_e'(apb_req.paddr);

    // decode and read mux
    always_comb begin
        addr_hit = 1'b1;
        cfg_addr = 1'b0;
        rd_data  = '0;
        case (addr)
            REG_CTRL: begin
                // start bit is self clearing, reads zero
                rd_data = '0;
            end
            REG_BASE: begin
                cfg_addr = 1'b1;
                rd_data  = cfg.base_pixel;
            end
            REG_COUNT: begin
                cfg_addr = 1'b1;
                rd_data  = {16'h0, cfg.pixel_count};
            end
            REG_PC: begin
                cfg_addr = 1'b1;
                rd_data  = cfg.entry_pc;
            end
            REG_STATUS: begin
                rd_data = {30'h0, done_flag, busy};
            end
            default: begin
                addr_hit = 1'b0;
            end
        endcase
    end

    // config is frozen while a patch runs
    assign cfg_locked = apb_req.pwrite && cfg_addr && busy;
    assign wr_ok      = access && apb_req.pwrite && addr_hit && !cfg_locked;

    assign apb_rsp.prdata  = rd_data;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access && (!addr_hit || cfg_locked);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg       <= '0;
            start     <= 1'b0;
            done_flag <= 1'b0;
        end else begin
            // one cycle pulse, dropped if a patch is still running
            start <= wr_ok && (addr == REG_CTRL) && apb_req.pwdata[0] && !busy;
            if (wr_ok) begin
                case (addr)
                    REG_BASE:  cfg.base_pixel  <= apb_req.pwdata;
                    REG_COUNT: cfg.pixel_count <= apb_req.pwdata[15:0];
                    REG_PC:    cfg.entry_pc    <= apb_req.pwdata;
                    default:   ;
                endcase
            end
            // sticky done, new start wins over a late done pulse
            if (start) begin
                done_flag <= 1'b0;
            end else if (patch_done) begin
                done_flag <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/job_generator.sv
`default_nettype none

module job_generator #(
    parameter int NUM_THREAD = rt_dispatch_pkg::NUM_THREAD
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         start,
    input  wire rt_dispatch_pkg::patch_cfg_t  cfg,
    output logic                              ctx_valid,
    output rt_dispatch_pkg::job_ctx_t         ctx,
    input  wire logic                         ctx_ready,
    input  wire logic                         thread_free,
    input  wire rt_dispatch_pkg::thread_id_t  thread_free_id,
    output logic                              gen_idle
);
    import rt_dispatch_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } gen_state_e;

    gen_state_e            state;
    logic [NUM_THREAD-1:0] free_map;
    logic [NUM_THREAD-1:0] alloc_mask;
    logic [NUM_THREAD-1:0] ret_mask;
    thread_id_t            free_id;
    logic                  free_any;
    logic [31:0]           next_pix;
    logic [15:0]           remaining;
    logic [31:0]           entry_pc;
    logic [31:0]           pix_sel;
    logic [15:0]           rem_sel;
    logic [31:0]           pc_sel;
    logic                  load;

    assign gen_idle = (state == IDLE);

    // lowest free thread id
    always_comb begin
        free_id = '0;
        for (int i = NUM_THREAD - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                free_id = thread_id_t'(i);
            end
        end
    end
    assign free_any = |free_map;

    // first pixel comes straight from cfg so it lands one cycle after start
    assign pix_sel = gen_idle ? cfg.base_pixel : next_pix;
    assign rem_sel = gen_idle ? cfg.pixel_count : remaining;
    assign pc_sel  = gen_idle ? cfg.entry_pc : entry_pc;

    // output slot empty or draining, a pixel left and an id to give
    assign load = (!ctx_valid || ctx_ready) && free_any && (rem_sel != '0) &&
                  (gen_idle ? start : (state == RUN));

    always_comb begin
        alloc_mask = '0;
        ret_mask   = '0;
        if (load) begin
            alloc_mask[free_id] = 1'b1;
        end
        if (thread_free) begin
            ret_mask[thread_free_id] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            free_map  <= '1;
            ctx_valid <= 1'b0;
            next_pix  <= '0;
            remaining <= '0;
            entry_pc  <= '0;
        end else begin
            free_map <= (free_map & ~alloc_mask) | ret_mask;
            // valid holds until the queue takes it
            if (load) begin
                ctx_valid <= 1'b1;
            end else if (ctx_ready) begin
                ctx_valid <= 1'b0;
            end
            if (load) begin
                next_pix  <= pix_sel + 32'd1;
                remaining <= rem_sel - 16'd1;
            end else if (gen_idle && start) begin
                next_pix  <= cfg.base_pixel;
                remaining <= cfg.pixel_count;
            end
            if (gen_idle && start) begin
                entry_pc <= cfg.entry_pc;
            end
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    // last context handed over
                    if (remaining == '0 && !ctx_valid) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    // wait for every thread to retire
                    if (&free_map) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // context payload
    always_ff @(posedge clk) begin
        if (load) begin
            ctx.pixel_id  <= pix_sel;
            ctx.thread_id <= free_id;
            ctx.pc        <= pc_sel;
            ctx.sp        <= 32'(free_id) * STACK_STRIDE;
        end
    end

endmodule

`default_nettype wire

// File: logic/context_queue.sv
`default_nettype none

module context_queue #(
    parameter int QUEUE_DEPTH = rt_dispatch_pkg::QUEUE_DEPTH,
    parameter int NUM_RT      = rt_dispatch_pkg::NUM_RT
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       gen_valid,
    input  wire rt_dispatch_pkg::job_ctx_t  gen_ctx,
    output logic                            gen_ready,
    input  wire logic                       sw_push,
    input  wire rt_dispatch_pkg::job_ctx_t  sw_ctx,
    output logic                            head_valid,
    output rt_dispatch_pkg::job_ctx_t       head_ctx,
    input  wire logic                       pop,
    output logic                            empty
);
    import rt_dispatch_pkg::*;

    localparam int PTR_W       = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W       = $clog2(QUEUE_DEPTH + 1);
    // fresh contexts stop here, the rest is kept for switch returns
    localparam int FRESH_LIMIT = QUEUE_DEPTH - NUM_RT;

    job_ctx_t         mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;
    job_ctx_t         wr_data;

    // circular increment, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // switch return owns the write port that cycle
    assign gen_ready = !sw_push && (int'(count) < FRESH_LIMIT);
    assign wr_en     = sw_push || (gen_valid && gen_ready);
    assign wr_data   = sw_push ? sw_ctx : gen_ctx;
    assign rd_en     = pop && !empty;

    assign empty      = (count == '0);
    assign head_valid = !empty;
    assign head_ctx   = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/core_dispatcher.sv
`default_nettype none

module core_dispatcher #(
    parameter int NUM_RT = rt_dispatch_pkg::NUM_RT
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          head_valid,
    input  wire rt_dispatch_pkg::job_ctx_t     head_ctx,
    output logic                               pop,
    output logic [NUM_RT-1:0]                  dispatch,
    output rt_dispatch_pkg::job_ctx_t          dispatch_ctx,
    input  wire rt_dispatch_pkg::core_report_t core_report [NUM_RT],
    output logic                               thread_free,
    output rt_dispatch_pkg::thread_id_t        thread_free_id,
    output logic                               sw_push,
    output rt_dispatch_pkg::job_ctx_t          sw_ctx,
    input  wire logic                          gen_idle,
    input  wire logic                          queue_empty,
    output logic                               busy,
    output logic                               patch_done
);
    import rt_dispatch_pkg::*;

    localparam int IDX_W = (NUM_RT > 1) ? $clog2(NUM_RT) : 1;

    logic [NUM_RT-1:0] core_busy;
    logic [NUM_RT-1:0] free_pend;
    logic [NUM_RT-1:0] sw_pend;
    logic [NUM_RT-1:0] done_mask;
    logic [NUM_RT-1:0] switch_mask;
    logic [NUM_RT-1:0] free_serve;
    logic [NUM_RT-1:0] sw_serve;
    logic [NUM_RT-1:0] idle_mask;
    logic [NUM_RT-1:0] issue_mask;
    logic [IDX_W-1:0]  free_idx;
    logic [IDX_W-1:0]  sw_idx;
    thread_id_t        core_tid [NUM_RT];
    job_ctx_t          pend_ctx [NUM_RT];
    logic              issue;
    logic              all_idle;
    logic              active;

    // isolate lowest set bit
    function automatic logic [NUM_RT-1:0] lowest(input logic [NUM_RT-1:0] v);
        return v & (~v + 1'b1);
    endfunction

    function automatic logic [IDX_W-1:0] to_idx(input logic [NUM_RT-1:0] oh);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < NUM_RT; i++) begin
            if (oh[i]) begin
                idx = IDX_W'(i);
            end
        end
        return idx;
    endfunction

    always_comb begin
        for (int i = 0; i < NUM_RT; i++) begin
            done_mask[i]   = core_report[i].task_done;
            switch_mask[i] = core_report[i].context_switch;
        end
    end

    // one thread free and one switch push per cycle, lowest core first
    assign free_serve = lowest(free_pend);
    assign sw_serve   = lowest(sw_pend);
    assign free_idx   = to_idx(free_serve);
    assign sw_idx     = to_idx(sw_serve);

    assign thread_free    = |free_pend;
    assign thread_free_id = pend_ctx[free_idx].thread_id;
    assign sw_push        = |sw_pend;
    assign sw_ctx         = pend_ctx[sw_idx];

    // a core with an unserved report keeps its pend_ctx slot, so it waits
    assign idle_mask  = ~core_busy & ~((free_pend & ~free_serve) | (sw_pend & ~sw_serve));
    assign issue_mask = head_valid ? lowest(idle_mask) : '0;
    assign issue      = |issue_mask;
    assign pop        = issue;

    assign all_idle = gen_idle && queue_empty && !(|core_busy) &&
                      !(|free_pend) && !(|sw_pend);
    assign busy     = !all_idle;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            core_busy  <= '0;
            free_pend  <= '0;
            sw_pend    <= '0;
            dispatch   <= '0;
            active     <= 1'b0;
            patch_done <= 1'b0;
        end else begin
            // occupy on issue, release on either report
            core_busy <= (core_busy & ~(done_mask | switch_mask)) | issue_mask;
            free_pend <= (free_pend & ~free_serve) | done_mask;
            sw_pend   <= (sw_pend & ~sw_serve) | switch_mask;
            dispatch  <= issue_mask;
            // patch seen running once the generator leaves idle
            if (active) begin
                active <= !all_idle;
            end else begin
                active <= !gen_idle;
            end
            // single cycle pulse per patch
            patch_done <= active && all_idle;
        end
    end

    // context payloads
    always_ff @(posedge clk) begin
        if (issue) begin
            dispatch_ctx <= head_ctx;
        end
        for (int i = 0; i < NUM_RT; i++) begin
            if (issue_mask[i]) begin
                core_tid[i] <= head_ctx.thread_id;
            end
            // switch keeps the core's saved state, done only needs the id
            if (core_report[i].context_switch) begin
                pend_ctx[i] <= core_report[i].saved;
            end else if (core_report[i].task_done) begin
                pend_ctx[i].thread_id <= core_tid[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/rt_dispatch_top.sv
`default_nettype none

module rt_dispatch_top #(
    parameter int NUM_RT      = rt_dispatch_pkg::NUM_RT,
    parameter int NUM_THREAD  = rt_dispatch_pkg::NUM_THREAD,
    parameter int QUEUE_DEPTH = rt_dispatch_pkg::QUEUE_DEPTH
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire rt_dispatch_pkg::apb_req_t     apb_req,
    output rt_dispatch_pkg::apb_rsp_t          apb_rsp,
    output logic [NUM_RT-1:0]                  dispatch,
    output rt_dispatch_pkg::job_ctx_t          dispatch_ctx,
    input  wire rt_dispatch_pkg::core_report_t core_report [NUM_RT],
    output logic                               patch_done
);
    import rt_dispatch_pkg::*;

    patch_cfg_t cfg;
    logic       start;
    logic       busy;
    logic       gen_valid;
    logic       gen_ready;
    logic       gen_idle;
    job_ctx_t   gen_ctx;
    logic       head_valid;
    job_ctx_t   head_ctx;
    logic       pop;
    logic       queue_empty;
    logic       sw_push;
    job_ctx_t   sw_ctx;
    logic       thread_free;
    thread_id_t thread_free_id;

    // register block
    patch_regs patch_regs_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .patch_done (patch_done),
        .busy       (busy),
        .start      (start),
        .cfg        (cfg)
    );

    // pixel walk and thread pool
    job_generator #(
        .NUM_THREAD (NUM_THREAD)
    ) job_generator_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .cfg            (cfg),
        .ctx_valid      (gen_valid),
        .ctx            (gen_ctx),
        .ctx_ready      (gen_ready),
        .thread_free    (thread_free),
        .thread_free_id (thread_free_id),
        .gen_idle       (gen_idle)
    );

    // fresh and switched contexts share this queue
    context_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .NUM_RT      (NUM_RT)
    ) context_queue_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .gen_valid  (gen_valid),
        .gen_ctx    (gen_ctx),
        .gen_ready  (gen_ready),
        .sw_push    (sw_push),
        .sw_ctx     (sw_ctx),
        .head_valid (head_valid),
        .head_ctx   (head_ctx),
        .pop        (pop),
        .empty      (queue_empty)
    );

    // core side
    core_dispatcher #(
        .NUM_RT (NUM_RT)
    ) core_dispatcher_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .head_valid     (head_valid),
        .head_ctx       (head_ctx),
        .pop            (pop),
        .dispatch       (dispatch),
        .dispatch_ctx   (dispatch_ctx),
        .core_report    (core_report),
        .thread_free    (thread_free),
        .thread_free_id (thread_free_id),
        .sw_push        (sw_push),
        .sw_ctx         (sw_ctx),
        .gen_idle       (gen_idle),
        .queue_empty    (queue_empty),
        .busy           (busy),
        .patch_done     (patch_done)
    );

endmodule

`default_nettype wire

// File: tb/rt_dispatch_assertions.sv
`default_nettype none

module rt_dispatch_assertions #(
    parameter int NUM_RT  = 4,
    parameter int OCC_MAX = 8
) (
    input wire logic              clk,
    input wire logic              rst_n,
    input wire logic [31:0]       occ,
    input wire logic              push,
    input wire logic              pull,
    input wire logic [NUM_RT-1:0] onehot_vec,
    input wire logic [NUM_RT-1:0] release_vec
);

    // cores holding a context from dispatch until their report
    logic [NUM_RT-1:0] held;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held <= '0;
        end else begin
            held <= (held & ~release_vec) | onehot_vec;
        end
    end

    // queue occupancy stays within its depth
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        occ <= OCC_MAX)
        else $error("queue occupancy above depth");

    // no write into a full queue without a read
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        !((occ == OCC_MAX) && push && !pull))
        else $error("write into full queue");

    a_dispatch_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(onehot_vec))
        else $error("dispatch not one-hot");

    // no second context for a core before it reports
    a_no_busy_issue: assert property (@(posedge clk) disable iff (!rst_n)
        (onehot_vec & held) == '0)
        else $error("busy core dispatched again");

endmodule

bind context_queue rt_dispatch_assertions #(
    .NUM_RT  (NUM_RT),
    .OCC_MAX (QUEUE_DEPTH)
) queue_checks (
    .clk         (clk),
    .rst_n       (rst_n),
    .occ         (32'(count)),
    .push        (wr_en),
    .pull        (rd_en),
    .onehot_vec  ('0),
    .release_vec ('0)
);

bind core_dispatcher rt_dispatch_assertions #(
    .NUM_RT  (NUM_RT),
    .OCC_MAX (1)
) dispatch_checks (
    .clk         (clk),
    .rst_n       (rst_n),
    .occ         (32'd0),
    .push        (1'b0),
    .pull        (1'b0),
    .onehot_vec  (dispatch),
    .release_vec (done_mask | switch_mask)
);

`default_nettype wire

// File: tb/rt_dispatch_tb.sv
`default_nettype none

module rt_dispatch_tb;
    import rt_dispatch_pkg::*;

    localparam int MAX_CASES = 4;
    localparam int MAX_PIX   = 64;
    localparam int SLOTS     = MAX_CASES * MAX_PIX;

    logic         clk = 1'b0;
    logic         rst_n;
    apb_req_t     apb_req;
    apb_rsp_t     apb_rsp;
    logic [NUM_RT-1:0] dispatch;
    job_ctx_t     dispatch_ctx;
    core_report_t core_report [NUM_RT] = '{default: '0};
    logic         patch_done;

    // vector words and current case settings
    logic [31:0] vec [0:5*MAX_CASES];
    logic [31:0] cur_base;
    logic [31:0] cur_count;
    logic [31:0] cur_pc;
    logic [31:0] cur_nsw;
    logic [31:0] cur_run;
    int          cur_case;

    // core model state owned by the negedge block
    logic [31:0] lcg_state = 32'hb50d;
    bit          active [NUM_RT] = '{default: 1'b0};
    int          run_left [NUM_RT] = '{default: 0};
    int          idle_cyc [NUM_RT] = '{default: 0};
    job_ctx_t    held [NUM_RT];
    // per pixel slot indexed by case and pixel offset
    bit          seen [SLOTS] = '{default: 1'b0};
    bit          running [SLOTS] = '{default: 1'b0};
    bit          finished [SLOTS] = '{default: 1'b0};
    int          sw_done [SLOTS] = '{default: 0};
    job_ctx_t    expect_ctx [SLOTS];
    // per case tallies
    int          first_count [MAX_CASES] = '{default: 0};
    int          done_count [MAX_CASES] = '{default: 0};
    int          max_busy [MAX_CASES] = '{default: 0};
    bit          done_seen [MAX_CASES] = '{default: 1'b0};

    rt_dispatch_top #(
        .NUM_RT      (NUM_RT),
        .NUM_THREAD  (NUM_THREAD),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) rt_dispatch_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .dispatch     (dispatch),
        .dispatch_ctx (dispatch_ctx),
        .core_report  (core_report),
        .patch_done   (patch_done)
    );

    always #2 clk = ~clk;

    task check(input logic [31:0] actual, input logic [31:0] expected, input string msg);
        if (actual !== expected) begin
            $display("ERROR %0t: %s got %h expected %h", $time, msg, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task timed_out(input string msg);
        $display("timeout while waiting: %s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout");
    endtask

    // jitter source for core run lengths
    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // setup phase then access phase sampled mid low phase
    task apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                  output logic [31:0] rdata, output logic err);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1;
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        // zero wait states
        check(32'(apb_rsp.pready), 32'd1, "pready in access phase");
        @(negedge clk);
        apb_req = '0;
    endtask

    task apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        check(32'(err), 32'(exp_err), "pslverr on write");
    endtask

    task apb_read_check(input logic [7:0] addr, input logic [31:0] exp, input string msg);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b0, addr, 32'h0, rd, err);
        check(32'(err), 32'd0, "pslverr on read");
        check(rd, exp, msg);
    endtask

    task check_register_map();
        logic [31:0] rd;
        logic        err;
        apb_write(REG_BASE, 32'hdeadbeef, 1'b0);
        apb_write(REG_COUNT, 32'hffff0042, 1'b0);
        apb_write(REG_PC, 32'h12345678, 1'b0);
        apb_read_check(REG_BASE, 32'hdeadbeef, "BASE readback");
        // only 16 count bits are kept
        apb_read_check(REG_COUNT, 32'h00000042, "COUNT readback");
        apb_read_check(REG_PC, 32'h12345678, "PC readback");
        apb_read_check(REG_CTRL, 32'h0, "CTRL readback");
        apb_read_check(REG_STATUS, 32'h0, "STATUS after reset");
        apb_xfer(1'b0, 8'h14, 32'h0, rd, err);
        check(32'(err), 32'd1, "pslverr on unmapped read");
        apb_xfer(1'b1, 8'h20, 32'h5, rd, err);
        check(32'(err), 32'd1, "pslverr on unmapped write");
    endtask

    // record one dispatch and check it against the model
    task take_dispatch();
        int          k;
        int          slot;
        logic [31:0] off;
        logic        clash;
        job_ctx_t    c;
        k = 0;
        clash = 1'b0;
        c = dispatch_ctx;
        check(32'($onehot(dispatch)), 32'd1, "dispatch one-hot");
        for (int j = 0; j < NUM_RT; j++) begin
            if (dispatch[j]) begin
                k = j;
            end
        end
        check(32'(active[k]), 32'd0, "dispatch to busy core");
        // a lower core idle long enough should have won
        for (int j = 0; j < k; j++) begin
            if (!active[j] && idle_cyc[j] > NUM_RT + 2) begin
                check(32'(k), 32'(j), "dispatch not to lowest idle core");
            end
        end
        off = c.pixel_id - cur_base;
        if (off >= cur_count) begin
            check(c.pixel_id, cur_base, "pixel outside patch");
        end
        slot = cur_case * MAX_PIX + int'(off);
        for (int j = 0; j < NUM_RT; j++) begin
            if (active[j] && held[j].thread_id == c.thread_id) begin
                clash = 1'b1;
            end
        end
        check(32'(clash), 32'd0, "thread id held by two cores");
        check(32'(running[slot]), 32'd0, "pixel dispatched while running");
        check(32'(finished[slot]), 32'd0, "finished pixel dispatched again");
        if (!seen[slot]) begin
            check(c.pc, cur_pc, "fresh context pc");
            check(c.sp, 32'(c.thread_id) * 32'h400, "fresh context sp");
            seen[slot] = 1'b1;
            first_count[cur_case]++;
        end else begin
            check(32'(c.thread_id), 32'(expect_ctx[slot].thread_id), "resumed thread id");
            check(c.pc, expect_ctx[slot].pc, "resumed pc");
            check(c.sp, expect_ctx[slot].sp, "resumed sp");
        end
        running[slot] = 1'b1;
        active[k]     = 1'b1;
        held[k]       = c;
        idle_cyc[k]   = 0;
        run_left[k]   = int'(cur_run + (lcg_next() & 32'h3));
    endtask

    // core models with one cycle reports
    always @(negedge clk) begin
        int slot;
        int n_busy;
        n_busy = 0;
        if (rst_n) begin
            for (int i = 0; i < NUM_RT; i++) begin
                core_report[i] = '0;
            end
            if (patch_done) begin
                check(32'(done_count[cur_case]), cur_count, "patch_done before all tasks");
                done_seen[cur_case] = 1'b1;
            end
            if (dispatch != '0) begin
                take_dispatch();
            end
            for (int i = 0; i < NUM_RT; i++) begin
                if (active[i]) begin
                    n_busy++;
                    run_left[i]--;
                    if (run_left[i] == 0) begin
                        slot = cur_case * MAX_PIX + int'(held[i].pixel_id - cur_base);
                        active[i]     = 1'b0;
                        running[slot] = 1'b0;
                        core_report[i].saved = held[i];
                        if (sw_done[slot] < int'(cur_nsw)) begin
                            sw_done[slot]++;
                            core_report[i].context_switch = 1'b1;
                            core_report[i].saved.pc = held[i].pc + 32'd4;
                            core_report[i].saved.sp = held[i].sp - 32'd16;
                            expect_ctx[slot] = core_report[i].saved;
                        end else begin
                            core_report[i].task_done = 1'b1;
                            finished[slot] = 1'b1;
                            done_count[cur_case]++;
                        end
                    end
                end else begin
                    idle_cyc[i]++;
                end
            end
            if (n_busy > max_busy[cur_case]) begin
                max_busy[cur_case] = n_busy;
            end
        end
    end

    task run_case(input int c);
        int t;
        cur_case  = c;
        cur_base  = vec[1 + 5 * c];
        cur_count = vec[2 + 5 * c];
        cur_pc    = vec[3 + 5 * c];
        cur_nsw   = vec[4 + 5 * c];
        cur_run   = vec[5 + 5 * c];
        if (cur_count == 0 || cur_count > MAX_PIX) begin
            check(cur_count, 32'(MAX_PIX), "vector pixel count out of range");
        end
        apb_write(REG_BASE, cur_base, 1'b0);
        apb_write(REG_COUNT, cur_count, 1'b0);
        apb_write(REG_PC, cur_pc, 1'b0);
        apb_read_check(REG_STATUS, (c == 0) ? 32'h0 : 32'h2, "STATUS before start");
        apb_write(REG_CTRL, 32'h1, 1'b0);
        // config frozen while busy
        apb_write(REG_BASE, ~cur_base, 1'b1);
        apb_read_check(REG_BASE, cur_base, "BASE after locked write");
        apb_read_check(REG_STATUS, 32'h1, "STATUS while busy");
        t = 0;
        while (!done_seen[c]) begin
            @(posedge clk);
            t++;
            if (t > 20000) begin
                timed_out("patch_done never rose");
            end
        end
        check(32'(first_count[c]), cur_count, "first-time dispatch count");
        check(32'(done_count[c]), cur_count, "task_done count");
        if (cur_count > NUM_RT) begin
            check(32'(max_busy[c] > 1), 32'd1, "cores busy in parallel");
        end
        apb_read_check(REG_STATUS, 32'h2, "STATUS after patch");
    endtask

    initial begin
        int n;
        apb_req   = '0;
        rst_n     = 1'b0;
        cur_case  = 0;
        cur_base  = '0;
        cur_count = '0;
        cur_pc    = '0;
        cur_nsw   = '0;
        cur_run   = 32'd1;
        $readmemh("tb/rt_dispatch_vectors.txt", vec);
        n = int'(vec[0]);
        if (n < 1 || n > MAX_CASES) begin
            check(vec[0], 32'(MAX_CASES), "vector case count");
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_register_map();
        for (int c = 0; c < n; c++) begin
            run_case(c);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/rt_dispatch_vectors.txt
// per case: base_pixel pixel_count entry_pc switches_per_job run_length (hex)
// first word is the number of cases
2
00000100 0000000c 80000000 00000002 00000006
00002000 00000014 40001000 00000001 00000009

// File: rt_dispatch.f
logic/rt_dispatch_pkg.sv
logic/patch_regs.sv
logic/job_generator.sv
logic/context_queue.sv
logic/core_dispatcher.sv
logic/rt_dispatch_top.sv
tb/rt_dispatch_assertions.sv
tb/rt_dispatch_tb.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module rt_dispatch_tb \
		-f rt_dispatch.f -o rt_dispatch_sim

run: build
	./obj_dir/rt_dispatch_sim > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TESTBENCH FAILED" sim.log
	grep -q "TESTBENCH PASSED" sim.log

lint:
	verilator --lint-only --timing --top-module rt_dispatch_tb -f rt_dispatch.f
	verilator --lint-only --top-module rt_dispatch_top \
		logic/rt_dispatch_pkg.sv logic/patch_regs.sv logic/job_generator.sv \
		logic/context_queue.sv logic/core_dispatcher.sv logic/rt_dispatch_top.sv

clean:
	rm -rf obj_dir sim.log
